// File: Bender.yml
package:
  name: cpu_core

sources:
  - target: any(rtl, test)
    files:
      - src/rv_pkg.sv
      - src/reg_file.sv
      - src/inst_fetch.sv
      - src/inst_decode.sv
      - src/execute_unit.sv
      - src/writeback_unit.sv
      - src/cpu_core.sv
  - target: test
    files:
      - verif/tb_cpu_core.sv

// File: list.f
src/rv_pkg.sv
src/reg_file.sv
src/inst_fetch.sv
src/inst_decode.sv
src/execute_unit.sv
src/writeback_unit.sv
src/cpu_core.sv
verif/tb_cpu_core.sv

// File: src/cpu_core.sv
// top of the in-order rv32i pipeline with instruction bus and retire report
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter rv_pkg::xlen_t reset_pc = 32'h0000_0000
) (
    input wire clk,
    input wire rst,
    output rv_pkg::wb_req_t wb_req,
    input wire rv_pkg::wb_rsp_t wb_rsp,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    fetch_t fetch;
    decoded_t decoded;
    exec_result_t result;
    redirect_t redirect;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t rs1_data;
    xlen_t rs2_data;

    inst_fetch #(
        .reset_pc(reset_pc)
    ) i_inst_fetch (
        .clk(clk),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .redirect(redirect),
        .fetch(fetch)
    );

    inst_decode i_inst_decode (
        .clk(clk),
        .rst(rst),
        .fetch(fetch),
        .redirect(redirect),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .decoded(decoded)
    );

    // redirect also flushes the decode register
    execute_unit i_execute_unit (
        .decoded(decoded),
        .result(result),
        .redirect(redirect)
    );

    writeback_unit i_writeback_unit (
        .clk(clk),
        .rst(rst),
        .result(result),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .retire(retire)
    );

endmodule

`default_nettype wire

// File: src/execute_unit.sv
// single-cycle execute: alu, branch compare and control-flow target for the redirect
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
    input wire rv_pkg::decoded_t decoded,
    output rv_pkg::exec_result_t result,
    output rv_pkg::redirect_t redirect
);
    import rv_pkg::*;

    xlen_t op_a;
    xlen_t op_b;
    xlen_t alu_out;
    xlen_t link;
    xlen_t target;
    logic [4:0] shamt;
    logic taken;
    logic jump;
    logic cond_branch;

    assign op_a = decoded.src_a_pc ? decoded.pc : decoded.rs1_data;
    assign op_b = decoded.src_b_imm ? decoded.imm : decoded.rs2_data;
    assign shamt = op_b[4:0];
    assign link = decoded.pc + 32'd4;

    always_comb begin
        case (decoded.alu_op)
            alu_add: alu_out = op_a + op_b;
            alu_sub: alu_out = op_a - op_b;
            alu_sll: alu_out = op_a << shamt;
            alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            alu_sltu: alu_out = {31'b0, op_a < op_b};
            alu_xor: alu_out = op_a ^ op_b;
            alu_srl: alu_out = op_a >> shamt;
            alu_sra: alu_out = xlen_t'($signed(op_a) >>> shamt);
            alu_or: alu_out = op_a | op_b;
            alu_and: alu_out = op_a & op_b;
            default: alu_out = op_a + op_b;
        endcase
    end

    // compare always uses the register operands
    always_comb begin
        case (decoded.branch_op)
            br_beq: taken = decoded.rs1_data == decoded.rs2_data;
            br_bne: taken = decoded.rs1_data != decoded.rs2_data;
            br_blt: taken = $signed(decoded.rs1_data) < $signed(decoded.rs2_data);
            br_bge: taken = $signed(decoded.rs1_data) >= $signed(decoded.rs2_data);
            br_bltu: taken = decoded.rs1_data < decoded.rs2_data;
            br_bgeu: taken = decoded.rs1_data >= decoded.rs2_data;
            br_jal, br_jalr: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign jump = (decoded.branch_op == br_jal) || (decoded.branch_op == br_jalr);
    assign cond_branch = (decoded.branch_op != br_none) && !jump;

    // jalr target drops bit 0
    assign target = (decoded.branch_op == br_jalr) ? {alu_out[31:1], 1'b0} : alu_out;

    assign result = '{
        valid: decoded.valid,
        pc: decoded.pc,
        rd: cond_branch ? 5'd0 : decoded.rd,
        data: jump ? link : alu_out
    };

    assign redirect = '{valid: decoded.valid && taken, target: target};

endmodule

`default_nettype wire

// File: src/inst_decode.sv
// decode stage: splits the fetched word, builds immediates and holds the execute register
`timescale 1ns/1ps
`default_nettype none

module inst_decode (
    input wire clk,
    input wire rst,
    input wire rv_pkg::fetch_t fetch,
    input wire rv_pkg::redirect_t redirect,
    output rv_pkg::reg_addr_t rs1_addr,
    output rv_pkg::reg_addr_t rs2_addr,
    input wire rv_pkg::xlen_t rs1_data,
    input wire rv_pkg::xlen_t rs2_data,
    output rv_pkg::decoded_t decoded
);
    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic funct7_b5;
    xlen_t imm_i;
    xlen_t imm_u;
    xlen_t imm_b;
    xlen_t imm_j;
    decoded_t nxt;
    decoded_t payload_q;
    logic valid_q;

    // sub only for register ops, sra/srai picked by bit 30
    function automatic alu_op_e alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic reg_op);
        case (f3)
            3'b000: return (reg_op && alt) ? alu_sub : alu_add;
            3'b001: return alu_sll;
            3'b010: return alu_slt;
            3'b011: return alu_sltu;
            3'b100: return alu_xor;
            3'b101: return alt ? alu_sra : alu_srl;
            3'b110: return alu_or;
            default: return alu_and;
        endcase
    endfunction

    function automatic branch_op_e br_sel(input logic [2:0] f3);
        case (f3)
            3'b000: return br_beq;
            3'b001: return br_bne;
            3'b100: return br_blt;
            3'b101: return br_bge;
            3'b110: return br_bltu;
            3'b111: return br_bgeu;
            default: return br_none;
        endcase
    endfunction

    assign opcode = fetch.inst[6:0];
    assign funct3 = fetch.inst[14:12];
    assign funct7_b5 = fetch.inst[30];

    assign imm_i = {{20{fetch.inst[31]}}, fetch.inst[31:20]};
    assign imm_u = {fetch.inst[31:12], 12'b0};
    assign imm_b = {{19{fetch.inst[31]}}, fetch.inst[31], fetch.inst[7],
                    fetch.inst[30:25], fetch.inst[11:8], 1'b0};
    assign imm_j = {{11{fetch.inst[31]}}, fetch.inst[31], fetch.inst[19:12],
                    fetch.inst[20], fetch.inst[30:21], 1'b0};

    // lui reads x0 so the alu adds the immediate to zero
    assign rs1_addr = (opcode == OPC_LUI) ? 5'd0 : fetch.inst[19:15];
    assign rs2_addr = fetch.inst[24:20];

    always_comb begin
        nxt = '0;
        nxt.valid = fetch.valid && !redirect.valid;
        nxt.pc = fetch.pc;
        nxt.rd = fetch.inst[11:7];
        nxt.alu_op = alu_add;
        nxt.branch_op = br_none;
        nxt.src_a_pc = 1'b0;
        nxt.src_b_imm = 1'b1;
        nxt.imm = imm_i;
        nxt.rs1_data = rs1_data;
        nxt.rs2_data = rs2_data;
        case (opcode)
            OPC_OP: begin
                nxt.src_b_imm = 1'b0;
                nxt.alu_op = alu_sel(funct3, funct7_b5, 1'b1);
            end
            OPC_OP_IMM: nxt.alu_op = alu_sel(funct3, funct7_b5, 1'b0);
            OPC_LUI: nxt.imm = imm_u;
            OPC_AUIPC: begin
                nxt.src_a_pc = 1'b1;
                nxt.imm = imm_u;
            end
            // alu forms the target for pc-relative control flow
            OPC_BRANCH: begin
                nxt.src_a_pc = 1'b1;
                nxt.imm = imm_b;
                nxt.branch_op = br_sel(funct3);
            end
            OPC_JAL: begin
                nxt.src_a_pc = 1'b1;
                nxt.imm = imm_j;
                nxt.branch_op = br_jal;
            end
            OPC_JALR: nxt.branch_op = br_jalr;
            // unknown opcode retires as a no-op
            default: nxt.rd = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= nxt.valid;
        end
    end

    always_ff @(posedge clk) begin
        payload_q <= nxt;
    end

    always_comb begin
        decoded = payload_q;
        decoded.valid = valid_q;
    end

endmodule

`default_nettype wire

// File: src/inst_fetch.sv
// instruction fetch stage with pc and a wishbone read master; feeds the decode stage
`timescale 1ns/1ps
`default_nettype none

module inst_fetch #(
    parameter rv_pkg::xlen_t reset_pc = 32'h0000_0000
) (
    input wire clk,
    input wire rst,
    output rv_pkg::wb_req_t wb_req,
    input wire rv_pkg::wb_rsp_t wb_rsp,
    input wire rv_pkg::redirect_t redirect,
    output rv_pkg::fetch_t fetch
);
    import rv_pkg::*;

    xlen_t pc;
    xlen_t pend_target;
    logic cyc;
    logic discard;
    logic done;
    logic fetch_valid;
    xlen_t fetch_pc;
    logic [31:0] fetch_inst;

    assign done = cyc && wb_rsp.ack;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pc <= reset_pc;
            cyc <= 1'b0;
            discard <= 1'b0;
            fetch_valid <= 1'b0;
        end else begin
            // anything on the bus is younger than a redirecting instruction
            fetch_valid <= done && !discard && !redirect.valid;
            if (!cyc) begin
                // idle cycle between requests, adr may still move
                cyc <= 1'b1;
                if (redirect.valid) begin
                    pc <= redirect.target;
                end
            end else if (done) begin
                cyc <= 1'b0;
                discard <= 1'b0;
                if (redirect.valid) begin
                    pc <= redirect.target;
                end else if (discard) begin
                    pc <= pend_target;
                end else begin
                    pc <= pc + 32'd4;
                end
            end else if (redirect.valid) begin
                // adr must hold, so finish this one and drop its data
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && !done && redirect.valid) begin
            pend_target <= redirect.target;
        end
        if (done) begin
            fetch_pc <= pc;
            fetch_inst <= wb_rsp.dat;
        end
    end

    assign wb_req = '{cyc: cyc, stb: cyc, adr: pc};
    assign fetch = '{valid: fetch_valid, pc: fetch_pc, inst: fetch_inst};

endmodule

`default_nettype wire

// File: src/reg_file.sv
// integer register file with two asynchronous read ports and one write port
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input wire clk,
    input wire rst,
    input wire we,
    input wire rv_pkg::reg_addr_t waddr,
    input wire rv_pkg::xlen_t wdata,
    input wire rv_pkg::reg_addr_t raddr1,
    input wire rv_pkg::reg_addr_t raddr2,
    output rv_pkg::xlen_t rdata1,
    output rv_pkg::xlen_t rdata2
);
    import rv_pkg::*;

    // x0 has no storage
    xlen_t regs [1:31];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: src/rv_pkg.sv
// shared word types, opcodes, operation codes and stage records for the rv32i core
`default_nettype none

package rv_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0] reg_addr_t;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC = 7'b0010111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_e;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_jal,
        br_jalr
    } branch_op_e;

    typedef struct packed {
        logic valid;
        xlen_t pc;
        logic [31:0] inst;
    } fetch_t;

    // operand a is the pc when src_a_pc, operand b the immediate when src_b_imm
    typedef struct packed {
        logic valid;
        xlen_t pc;
        reg_addr_t rd;
        alu_op_e alu_op;
        branch_op_e branch_op;
        logic src_a_pc;
        logic src_b_imm;
        xlen_t imm;
        xlen_t rs1_data;
        xlen_t rs2_data;
    } decoded_t;

    // rd of zero means nothing is written
    typedef struct packed {
        logic valid;
        xlen_t pc;
        reg_addr_t rd;
        xlen_t data;
    } exec_result_t;

    typedef exec_result_t retire_t;

    typedef struct packed {
        logic valid;
        xlen_t target;
    } redirect_t;

    // read-only wishbone classic master
    typedef struct packed {
        logic cyc;
        logic stb;
        xlen_t adr;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

`default_nettype wire

// File: src/writeback_unit.sv
// write-back stage: retire register, register file write and operand forwarding to decode
`timescale 1ns/1ps
`default_nettype none

module writeback_unit (
    input wire clk,
    input wire rst,
    input wire rv_pkg::exec_result_t result,
    input wire rv_pkg::reg_addr_t rs1_addr,
    input wire rv_pkg::reg_addr_t rs2_addr,
    output rv_pkg::xlen_t rs1_data,
    output rv_pkg::xlen_t rs2_data,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    logic retire_valid;
    xlen_t retire_pc;
    reg_addr_t retire_rd;
    xlen_t retire_data;
    xlen_t rf_data1;
    xlen_t rf_data2;

    // youngest producer wins, then the retire register, then the file
    function automatic xlen_t fwd(input reg_addr_t addr, input exec_result_t ex,
                                  input retire_t wb, input xlen_t rf);
        if (ex.valid && ex.rd != '0 && ex.rd == addr) begin
            return ex.data;
        end else if (wb.valid && wb.rd != '0 && wb.rd == addr) begin
            return wb.data;
        end else begin
            return rf;
        end
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            retire_valid <= 1'b0;
        end else begin
            retire_valid <= result.valid;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc <= result.pc;
        retire_rd <= result.rd;
        retire_data <= result.data;
    end

    assign retire = '{valid: retire_valid, pc: retire_pc, rd: retire_rd, data: retire_data};

    reg_file i_reg_file (
        .clk(clk),
        .rst(rst),
        .we(retire_valid && retire_rd != '0),
        .waddr(retire_rd),
        .wdata(retire_data),
        .raddr1(rs1_addr),
        .raddr2(rs2_addr),
        .rdata1(rf_data1),
        .rdata2(rf_data2)
    );

    assign rs1_data = fwd(rs1_addr, result, retire, rf_data1);
    assign rs2_data = fwd(rs2_addr, result, retire, rf_data2);

endmodule

`default_nettype wire

// File: verif/tb_cpu_core.sv
// testbench for cpu_core; runs a fixed and random program and checks every retire against a model
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import rv_pkg::*;

    localparam xlen_t reset_pc = 32'h0000_0200;
    localparam int mem_words = 128;
    localparam int random_count = 40;

    logic clk;
    logic rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    retire_t retire;

    logic [31:0] mem [0:mem_words-1];
    int prog_len;
    logic [31:0] lcg_state;
    xlen_t ref_regs [0:31];
    xlen_t ref_pc;
    retire_t expected [$];
    logic done;
    int cycles;

    // bus monitor state
    logic cyc_prev;
    logic seen_req;
    xlen_t last_ack_adr;
    xlen_t last_target;

    cpu_core #(
        .reset_pc(reset_pc)
    ) i_cpu_core (
        .clk(clk),
        .rst(rst),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp),
        .retire(retire)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] v;
        v = lcg_next();
        return v[31:16] % n;
    endfunction

    // unused words decode as a custom opcode, tagged with their address
    function automatic logic [31:0] fill_word(input xlen_t adr);
        return {adr[24:0] ^ adr[31:7], 7'b0001011};
    endfunction

    function automatic logic [31:0] fetch_word(input xlen_t adr);
        xlen_t idx;
        idx = (adr - reset_pc) >> 2;
        if (adr >= reset_pc && idx < mem_words && adr[1:0] == 2'b00) begin
            return mem[idx];
        end
        return fill_word(adr);
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] random_alu_inst();
        int unsigned kind;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] f3;
        logic alt;
        logic [11:0] imm;
        logic [31:0] v;
        kind = rand_below(3);
        rd = 5'(rand_below(8));
        rs1 = 5'(rand_below(8));
        rs2 = 5'(rand_below(8));
        f3 = 3'(rand_below(8));
        alt = 1'(rand_below(2));
        v = lcg_next();
        case (kind)
            0: return enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                            rs2, rs1, f3, rd);
            1: begin
                // shifts keep a legal funct7
                if (f3 == 3'b001) begin
                    imm = {7'h00, rs2};
                end else if (f3 == 3'b101) begin
                    imm = {alt ? 7'h20 : 7'h00, rs2};
                end else begin
                    imm = v[27:16];
                end
                return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
            end
            default: return enc_u(v[31:12], rd, OPC_LUI);
        endcase
    endfunction

    task automatic append_inst(input logic [31:0] w);
        mem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(reset_pc + 4 * i);
        end
        prog_len = 0;
        // alu ops with dependencies at distance 1, 2 and 3
        append_inst(enc_u(20'h12345, 5'd1, OPC_LUI));
        append_inst(enc_i(12'h678, 5'd1, 3'b000, 5'd1, OPC_OP_IMM));
        append_inst(enc_u(20'h00001, 5'd2, OPC_AUIPC));
        append_inst(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        append_inst(enc_r(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
        append_inst(enc_i(12'd5, 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
        append_inst(enc_r(7'h00, 5'd1, 5'd0, 3'b000, 5'd5));
        // x1 = 5, x2 = -3, then each branch taken and not taken
        append_inst(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
        append_inst(enc_i(-12'sd3, 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd1, 5'd1, 3'b000));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b000));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b001));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd1, 5'd1, 3'b001));
        append_inst(enc_b(13'd8, 5'd1, 5'd2, 3'b100));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b100));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b101));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd1, 5'd2, 3'b101));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b110));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd1, 5'd2, 3'b110));
        append_inst(enc_b(13'd8, 5'd1, 5'd2, 3'b111));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_b(13'd8, 5'd2, 5'd1, 3'b111));
        // jal and jalr with an odd offset, then use both links
        append_inst(enc_j(21'd8, 5'd3));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_u(20'h00000, 5'd4, OPC_AUIPC));
        append_inst(enc_i(12'd13, 5'd4, 3'b000, 5'd5, OPC_JALR));
        append_inst(enc_i(12'd1, 5'd7, 3'b000, 5'd7, OPC_OP_IMM));
        append_inst(enc_r(7'h00, 5'd3, 5'd5, 3'b000, 5'd6));
        // custom opcode naming x7, then read x7 back
        append_inst({12'h123, 5'd1, 3'b000, 5'd7, 7'b0001011});
        append_inst(enc_r(7'h00, 5'd0, 5'd7, 3'b000, 5'd7));
        for (int i = 0; i < random_count; i++) begin
            append_inst(random_alu_inst());
        end
        append_inst(enc_j(21'd0, 5'd0));
    endtask

    function automatic xlen_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input xlen_t a, input xlen_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b011: return {31'b0, a < b};
            3'b100: return a ^ b;
            3'b101: return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes the instruction at ref_pc on ref_regs
    function automatic retire_t ref_step();
        logic [31:0] inst;
        reg_addr_t rd;
        logic [2:0] f3;
        logic alt;
        logic taken;
        xlen_t a;
        xlen_t b;
        xlen_t imm_i;
        xlen_t val;
        xlen_t next_pc;
        retire_t r;
        inst = fetch_word(ref_pc);
        rd = inst[11:7];
        f3 = inst[14:12];
        alt = inst[30];
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        val = '0;
        taken = 1'b0;
        next_pc = ref_pc + 32'd4;
        case (inst[6:0])
            OPC_OP: val = alu_ref(f3, alt, a, b);
            OPC_OP_IMM: val = alu_ref(f3, alt && f3 == 3'b101, a, imm_i);
            OPC_LUI: val = {inst[31:12], 12'b0};
            OPC_AUIPC: val = ref_pc + {inst[31:12], 12'b0};
            OPC_BRANCH: begin
                rd = '0;
                case (f3)
                    3'b000: taken = a == b;
                    3'b001: taken = a != b;
                    3'b100: taken = $signed(a) < $signed(b);
                    3'b101: taken = $signed(a) >= $signed(b);
                    3'b110: taken = a < b;
                    3'b111: taken = a >= b;
                    default: taken = 1'b0;
                endcase
                if (taken) begin
                    next_pc = ref_pc + {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                                        inst[11:8], 1'b0};
                end
            end
            OPC_JAL: begin
                val = ref_pc + 32'd4;
                next_pc = ref_pc + {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                                    inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                val = ref_pc + 32'd4;
                next_pc = (a + imm_i) & ~32'd1;
            end
            default: rd = '0;
        endcase
        r = '{valid: 1'b1, pc: ref_pc, rd: rd, data: val};
        if (rd != '0) begin
            ref_regs[rd] = val;
        end
        ref_pc = next_pc;
        return r;
    endfunction

    task automatic build_expected();
        xlen_t end_pc;
        end_pc = reset_pc + 4 * (prog_len - 1);
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        ref_pc = reset_pc;
        for (int n = 0; n < 4 * mem_words && ref_pc != end_pc; n++) begin
            expected.push_back(ref_step());
        end
        // a few turns of the final self loop
        for (int n = 0; n < 3; n++) begin
            expected.push_back(ref_step());
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // instruction memory with 0 to 3 wait cycles per request
    initial begin
        int wait_cnt;
        logic pending;
        wb_rsp = '0;
        pending = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (wb_rsp.ack) begin
                wb_rsp = '0;
                pending = 1'b0;
            end else if (wb_req.cyc && wb_req.stb) begin
                if (!pending) begin
                    pending = 1'b1;
                    wait_cnt = rand_below(4);
                end
                if (wait_cnt == 0) begin
                    wb_rsp.ack = 1'b1;
                    wb_rsp.dat = fetch_word(wb_req.adr);
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    // reset state and request addresses
    always @(negedge clk) begin
        if (!rst) begin
            check_value("wb_req.cyc", wb_req.cyc, 0);
            check_value("wb_req.stb", wb_req.stb, 0);
            check_value("retire.valid", retire.valid, 0);
            cyc_prev = 1'b0;
        end else begin
            if (wb_req.cyc && !cyc_prev) begin
                if (!seen_req) begin
                    check_value("wb_req.adr", wb_req.adr, reset_pc);
                    seen_req = 1'b1;
                end else if (wb_req.adr != last_ack_adr + 32'd4) begin
                    check_value("wb_req.adr", wb_req.adr, last_target);
                end
            end
            if (wb_req.cyc && wb_rsp.ack) begin
                last_ack_adr = wb_req.adr;
            end
            if (i_cpu_core.redirect.valid) begin
                last_target = i_cpu_core.redirect.target;
            end
            cyc_prev = wb_req.cyc;
        end
    end

    always @(negedge clk) begin
        retire_t want;
        if (rst && retire.valid && !done) begin
            want = expected.pop_front();
            check_value("retire.pc", retire.pc, want.pc);
            check_value("retire.rd", retire.rd, want.rd);
            if (want.rd != '0) begin
                check_value("retire.data", retire.data, want.data);
            end
            if (expected.size() == 0) begin
                done = 1'b1;
            end
        end
    end

    initial begin
        int limit;
        rst = 1'b0;
        done = 1'b0;
        seen_req = 1'b0;
        cyc_prev = 1'b0;
        last_ack_adr = '0;
        last_target = '0;
        lcg_state = 32'd62;
        build_program();
        build_expected();
        limit = 12 * expected.size() + 50;
        repeat (5) @(posedge clk);
        #1 rst = 1'b1;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (done) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("timeout after %0d cycles with %0d retires still missing",
                     cycles, expected.size());
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by timeout");
        end
    end

endmodule

`default_nettype wire
